//--- tests/i2c_stim.txt
# name write(1)/read(0) dev(hex) reg(hex) wdata(hex|rnd) rdata(hex|ref) nack strobe_again
# rnd takes a byte from the LFSR; ref takes the expected byte from the reference model.
wr_t0          1 50 03 a5  00  0 0
rd_t0          0 50 03 00  a5  0 0
wr_t1          1 51 03 5a  00  0 0
rd_t1          0 51 03 00  5a  0 0
wr_t2          1 52 0f 81  00  0 0
rd_t2          0 52 0f 00  81  0 0
wr_t3          1 53 00 7e  00  0 0
rd_t3          0 53 00 00  7e  0 0
rd_fresh       0 52 07 00  00  0 0
wr_nodev       1 60 03 ff  00  1 0
rd_nodev       0 60 03 00  00  1 0
rd_after_nodev 0 50 03 00  a5  0 0
wr_badreg      1 51 10 55  00  1 0
rd_badreg      0 51 20 00  00  1 0
rd_after_bad   0 51 03 00  5a  0 0
wr_same0       1 50 08 11  00  0 0
wr_same1       1 51 08 22  00  0 0
wr_same2       1 52 08 33  00  0 0
rd_same0       0 50 08 00  11  0 0
rd_same1       0 51 08 00  22  0 0
rd_same2       0 52 08 00  33  0 0
rnd_w0         1 50 0a rnd 00  0 0
rnd_w1         1 51 0b rnd 00  0 0
rnd_w2         1 53 0c rnd 00  0 0
rnd_w3         1 52 0d rnd 00  0 0
rnd_r0         0 50 0a 00  ref 0 0
rnd_r1         0 51 0b 00  ref 0 0
rnd_r2         0 53 0c 00  ref 0 0
rnd_r3         0 52 0d 00  ref 0 0
wr_busy        1 52 05 3c  00  0 1
rd_busy        0 52 05 00  3c  0 0
rd_ignored     0 53 05 00  00  0 0

//--- sim.f
src/i2c_pkg.sv
src/i2c_master.sv
src/i2c_reg_target.sv
src/i2c_subsys_top.sv
tests/tb_clock_gen.sv
tests/tb_i2c_subsys.sv

//--- Bender.yml
package:
  name: i2c_subsys

sources:
  - src/i2c_pkg.sv
  - src/i2c_master.sv
  - src/i2c_reg_target.sv
  - src/i2c_subsys_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_i2c_subsys.sv

//--- tests/tb_i2c_subsys.sv
`timescale 1ns/1ps

module tb_i2c_subsys;

	localparam int    clk_ns     = 40;
	localparam int    quiet_bits = 32; // bit periods watched for a stray done.
	localparam string stim_path  = "tests/i2c_stim.txt";

	logic              clk;
	logic              reset_n;
	logic              req_valid;
	i2c_pkg::i2c_req_t req;
	logic              busy;
	logic              done;
	i2c_pkg::i2c_rsp_t rsp;

	logic [15:0] lfsr;
	logic [7:0]  model [i2c_pkg::n_targets][i2c_pkg::n_regs]; // reference register files.
	string       lines[$];

	tb_clock_gen clkgen0 (
		.clk     (clk),
		.reset_n (reset_n)
	);

	i2c_subsys_top dut0 (
		.clk       (clk),
		.reset_n   (reset_n),
		.req_valid (req_valid),
		.req       (req),
		.busy      (busy),
		.done      (done),
		.rsp       (rsp)
	);

	// ========================================================================
	// helpers
	// ========================================================================

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [7:0] random_byte();
		logic [7:0] b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit.
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	task automatic abort_run();
		$display("Something failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_rsp(input string name, input i2c_pkg::i2c_rsp_t exp,
	                         input i2c_pkg::i2c_rsp_t act);
		if (act !== exp) begin
			$display("** Error %s: expected rdata=%h nack=%b, actual rdata=%h nack=%b",
			         name, exp.rdata, exp.nack, act.rdata, act.nack);
			abort_run();
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error %s: expected busy=%b, actual busy=%b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic watchdog(input int n_lines);
		#(longint'(n_lines) * 39 * i2c_pkg::bit_div * 2 * clk_ns);
		$display("timeout: done never arrived in the time allowed for %0d transfers", n_lines);
		abort_run();
	endtask

	task automatic read_stim();
		int    fd;
		string line;
		fd = $fopen(stim_path, "r");
		if (fd == 0) begin
			$display("could not open the stimulus file %s", stim_path);
			abort_run();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
					lines.push_back(line);
				end
			end
			$fclose(fd);
		end
	endtask

	// ========================================================================
	// one transfer
	// ========================================================================

	task automatic run_line(input string line);
		string             name;
		string             dtok;
		string             rtok;
		int                wr;
		int                nk;
		int                again;
		int                t;
		logic [6:0]        dev;
		logic [7:0]        ra;
		logic [7:0]        wd;
		logic              in_range;
		i2c_pkg::i2c_rsp_t exp;

		if ($sscanf(line, "%s %d %h %h %s %s %d %d",
		            name, wr, dev, ra, dtok, rtok, nk, again) != 8) begin
			$display("malformed stimulus line: %s", line);
			abort_run();
		end else begin
			wd       = (dtok == "rnd") ? random_byte() : 8'(dtok.atohex());
			t        = int'(dev) - int'(i2c_pkg::dev_base);
			in_range = (t >= 0) && (t < i2c_pkg::n_targets) && (ra < i2c_pkg::n_regs);

			exp.nack = nk[0];
			if (rtok == "ref") begin
				exp.rdata = in_range ? model[t][ra[3:0]] : 8'h00;
			end else begin
				exp.rdata = 8'(rtok.atohex());
			end

			@(negedge clk);
			req.write    = wr[0];
			req.dev      = dev;
			req.reg_addr = ra;
			req.wdata    = wd;
			req_valid    = 1'b1;
			@(negedge clk);
			req_valid = 1'b0;
			check_busy(name, 1'b1, busy);

			// second strobe mid-transfer, must be dropped.
			if (again != 0) begin
				repeat (3) @(negedge clk);
				req.dev   = dev + 7'd1;
				req.wdata = ~wd;
				req_valid = 1'b1;
				@(negedge clk);
				req_valid = 1'b0;
			end

			while (!done) @(negedge clk);
			check_rsp(name, exp, rsp);
			check_busy(name, 1'b0, busy);

			if (wr != 0 && nk == 0 && in_range) begin
				model[t][ra[3:0]] = wd;
			end

			if (again != 0) begin
				for (int i = 0; i < quiet_bits * i2c_pkg::bit_div; i++) begin
					@(negedge clk);
					if (done) begin
						$display("%s: a second done arrived for an ignored request", name);
						abort_run();
					end
				end
			end
		end
	endtask

	// ========================================================================
	// main
	// ========================================================================

	initial begin
		req_valid = 1'b0;
		req       = '0;
		lfsr      = 16'd39246;
		foreach (model[i, j]) begin
			model[i][j] = 8'h00;
		end

		read_stim();
		fork
			watchdog(lines.size());
		join_none

		@(posedge reset_n);
		@(negedge clk);
		foreach (lines[i]) begin
			run_line(lines[i]);
		end

		$display("Everything OK");
		$finish;
	end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset_n
);

	localparam int half_ns      = 20; // 40 ns period.
	localparam int reset_cycles = 3;

	initial begin
		clk = 1'b0;
		forever #(half_ns) clk = ~clk;
	end

	// release on a falling edge, like every other input.
	initial begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		reset_n = 1'b1;
	end

endmodule

//--- src/i2c_subsys_top.sv
`timescale 1ns/1ps

module i2c_subsys_top (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              req_valid,
	input  i2c_pkg::i2c_req_t req,
	output logic              busy,
	output logic              done,
	output i2c_pkg::i2c_rsp_t rsp
);

	logic                            sda;
	logic                            scl;
	logic                            m_sda_pull;
	logic                            m_scl_pull;
	logic [i2c_pkg::n_targets-1:0]   t_sda_pull;

	// ========================================================================
	// open-drain resolution
	// ========================================================================

	assign sda = !(m_sda_pull || (|t_sda_pull)); // low if anyone pulls.
	assign scl = !m_scl_pull;                     // only the master clocks.

	i2c_master m0 (
		.clk       (clk),
		.reset_n   (reset_n),
		.req_valid (req_valid),
		.req       (req),
		.sda_in    (sda),
		.scl_in    (scl),
		.sda_pull  (m_sda_pull),
		.scl_pull  (m_scl_pull),
		.busy      (busy),
		.done      (done),
		.rsp       (rsp)
	);

	// one target per device address.
	generate
		for (genvar k = 0; k < i2c_pkg::n_targets; k++) begin : g_target
			i2c_reg_target u_target (
				.clk      (clk),
				.reset_n  (reset_n),
				.my_dev   (i2c_pkg::dev_base + 7'(k)),
				.sda_in   (sda),
				.scl_in   (scl),
				.sda_pull (t_sda_pull[k])
			);
		end
	endgenerate

endmodule

//--- src/i2c_reg_target.sv
`timescale 1ns/1ps

module i2c_reg_target (
	input  logic       clk,
	input  logic       reset_n,
	input  logic [6:0] my_dev,
	input  logic       sda_in,
	input  logic       scl_in,
	output logic       sda_pull
);

	typedef enum logic [2:0] {
		tg_idle,
		tg_addr,
		tg_reg,
		tg_wdata,
		tg_rdata
	} tstate_t;

	tstate_t                    state;
	logic [1:0]                 sda_sync;
	logic [1:0]                 scl_sync;
	logic                       sda_prev;
	logic                       scl_prev;
	logic                       start_det;
	logic                       stop_det;
	logic                       scl_rise;
	logic                       scl_fall;
	logic                       wr_en;
	logic [3:0]                 bit_cnt;
	logic [7:0]                 rx_q;
	logic [7:0]                 tx_q;
	logic [i2c_pkg::reg_aw-1:0] ptr;
	logic [7:0]                 regs [i2c_pkg::n_regs];
	i2c_pkg::i2c_addr_byte_u    addr_u;

	// ========================================================================
	// line sync and bus events
	// ========================================================================

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			sda_sync <= 2'b11;
			scl_sync <= 2'b11;
			sda_prev <= 1'b1;
			scl_prev <= 1'b1;
		end else begin
			sda_sync <= {sda_sync[0], sda_in};
			scl_sync <= {scl_sync[0], scl_in};
			sda_prev <= sda_sync[1];
			scl_prev <= scl_sync[1];
		end
	end

	assign start_det = scl_sync[1] && scl_prev && sda_prev && !sda_sync[1];
	assign stop_det  = scl_sync[1] && scl_prev && !sda_prev && sda_sync[1];
	assign scl_rise  = scl_sync[1] && !scl_prev;
	assign scl_fall  = !scl_sync[1] && scl_prev;

	assign addr_u.raw = rx_q;
	assign wr_en      = (state == tg_wdata) && scl_fall && (bit_cnt == 4'd8);

	// ========================================================================
	// byte FSM
	// ========================================================================

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state    <= tg_idle;
			bit_cnt  <= '0;
			sda_pull <= 1'b0;
			ptr      <= '0;
			tx_q     <= '0;
		end else if (stop_det) begin
			state    <= tg_idle;
			sda_pull <= 1'b0;
		end else if (start_det) begin
			state    <= tg_addr; // repeated start lands here too.
			bit_cnt  <= '0;
			sda_pull <= 1'b0;
		end else if (state != tg_idle) begin
			if (scl_rise) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
			if (scl_fall && bit_cnt == 4'd8) begin
				// ACK bit begins.
				case (state)
					tg_addr: begin
						if (addr_u.fld.dev == my_dev) begin
							sda_pull <= 1'b1;
						end else begin
							state <= tg_idle; // not ours, stay quiet.
						end
					end
					tg_reg: begin
						if (rx_q[7:i2c_pkg::reg_aw] == '0) begin
							sda_pull <= 1'b1;
							ptr      <= rx_q[i2c_pkg::reg_aw-1:0];
						end else begin
							state <= tg_idle;
						end
					end
					tg_wdata: sda_pull <= 1'b1;
					default:  sda_pull <= 1'b0; // master answers read data.
				endcase
			end else if (scl_fall && bit_cnt == 4'd9) begin
				bit_cnt  <= '0;
				sda_pull <= 1'b0;
				case (state)
					tg_addr: begin
						if (addr_u.fld.rw) begin
							state    <= tg_rdata;
							sda_pull <= !regs[ptr][7];
							tx_q     <= {regs[ptr][6:0], 1'b0};
						end else begin
							state <= tg_reg;
						end
					end
					tg_reg:  state <= tg_wdata;
					default: state <= tg_idle;
				endcase
			end else if (scl_fall && state == tg_rdata) begin
				sda_pull <= !tx_q[7];
				tx_q     <= {tx_q[6:0], 1'b0};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state != tg_idle && scl_rise && bit_cnt < 4'd8) begin
			rx_q <= {rx_q[6:0], sda_sync[1]};
		end
	end

	// register file, written at the data ACK.
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			for (int i = 0; i < i2c_pkg::n_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[ptr] <= rx_q;
		end
	end

	a_idle_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		(state == tg_idle) |-> !sda_pull)
		else $error("target holds SDA while idle.");

endmodule

//--- src/i2c_master.sv
`timescale 1ns/1ps

module i2c_master (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              req_valid,
	input  i2c_pkg::i2c_req_t req,
	input  logic              sda_in,
	input  logic              scl_in,
	output logic              sda_pull,
	output logic              scl_pull,
	output logic              busy,
	output logic              done,
	output i2c_pkg::i2c_rsp_t rsp
);

	typedef enum logic [3:0] {
		st_idle,
		st_start,
		st_dev_addr,
		st_reg_addr,
		st_wr_data,
		st_restart,
		st_rd_dev_addr,
		st_rd_data,
		st_stop
	} state_t;

	state_t                      state;
	state_t                      next_byte;
	logic [i2c_pkg::cnt_w-1:0]   cnt;
	logic [3:0]                  bit_cnt;
	logic                        fin;
	logic                        nack_q;
	logic                        ack_q;
	logic [7:0]                  rx_q;
	logic [7:0]                  tx_byte;
	i2c_pkg::i2c_req_t           req_q;
	i2c_pkg::i2c_addr_byte_u     addr_wr;
	i2c_pkg::i2c_addr_byte_u     addr_rd;
	logic                        accept;
	logic                        in_byte;
	logic                        period_end;
	logic                        byte_end;
	logic                        sample_pt;
	logic                        scl_low;

	assign accept     = req_valid && !busy;
	assign in_byte    = state inside {st_dev_addr, st_reg_addr, st_wr_data,
	                                  st_rd_dev_addr, st_rd_data};
	assign period_end = (state != st_idle) && (cnt == i2c_pkg::tick_last);
	assign byte_end   = in_byte && period_end && (bit_cnt == 4'd8);
	assign sample_pt  = (cnt == i2c_pkg::tick_sample) && scl_in;
	assign scl_low    = (cnt < i2c_pkg::tick_scl_rise) || (cnt >= i2c_pkg::tick_scl_fall);

	always_comb begin
		addr_wr.fld.dev = req_q.dev;
		addr_wr.fld.rw  = 1'b0;
		addr_rd.fld.dev = req_q.dev;
		addr_rd.fld.rw  = 1'b1;
	end

	// byte on the wire; all ones releases SDA for read data.
	always_comb begin
		case (state)
			st_dev_addr:    tx_byte = addr_wr.raw;
			st_reg_addr:    tx_byte = req_q.reg_addr;
			st_wr_data:     tx_byte = req_q.wdata;
			st_rd_dev_addr: tx_byte = addr_rd.raw;
			default:        tx_byte = 8'hff;
		endcase
	end

	always_comb begin
		case (state)
			st_dev_addr:    next_byte = st_reg_addr;
			st_reg_addr:    next_byte = req_q.write ? st_wr_data : st_restart;
			st_rd_dev_addr: next_byte = st_rd_data;
			default:        next_byte = st_stop;
		endcase
	end

	// ========================================================================
	// bus drive
	// ========================================================================

	always_comb begin
		sda_pull = 1'b0;
		scl_pull = 1'b0;
		case (state)
			st_start: begin
				sda_pull = (cnt >= i2c_pkg::tick_sample); // SDA falls with SCL high.
				scl_pull = (cnt >= i2c_pkg::tick_scl_fall);
			end
			st_restart: begin
				sda_pull = (cnt >= i2c_pkg::tick_sample);
				scl_pull = scl_low;
			end
			st_stop: begin
				sda_pull = (cnt < i2c_pkg::tick_sample); // SDA rises with SCL high.
				scl_pull = (cnt < i2c_pkg::tick_scl_rise);
			end
			st_dev_addr, st_reg_addr, st_wr_data, st_rd_dev_addr, st_rd_data: begin
				// MSB first, ACK bit left released.
				sda_pull = (bit_cnt < 4'd8) && !tx_byte[3'd7 - bit_cnt[2:0]];
				scl_pull = scl_low;
			end
			default: begin
				sda_pull = 1'b0;
				scl_pull = 1'b0;
			end
		endcase
	end

	// ========================================================================
	// control
	// ========================================================================

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state   <= st_idle;
			cnt     <= '0;
			bit_cnt <= '0;
			busy    <= 1'b0;
			fin     <= 1'b0;
			done    <= 1'b0;
			nack_q  <= 1'b0;
			rsp     <= '0;
		end else begin
			done <= 1'b0;

			if (accept) begin
				busy   <= 1'b1;
				nack_q <= 1'b0;
			end

			// one cycle after stop, close the transfer.
			if (fin) begin
				fin  <= 1'b0;
				busy <= 1'b0;
				done <= 1'b1;
				rsp  <= '{rdata: rx_q, nack: nack_q};
			end

			if (state == st_idle || period_end) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end

			if (!in_byte || byte_end) begin
				bit_cnt <= '0;
			end else if (period_end) begin
				bit_cnt <= bit_cnt + 1'b1;
			end

			case (state)
				st_idle: begin
					if (busy && !fin) begin
						state <= st_start;
					end
				end
				st_start: begin
					if (period_end) begin
						state <= st_dev_addr;
					end
				end
				st_restart: begin
					if (period_end) begin
						state <= st_rd_dev_addr;
					end
				end
				st_stop: begin
					if (period_end) begin
						state <= st_idle;
						fin   <= 1'b1;
					end
				end
				default: begin
					if (byte_end) begin
						if (state != st_rd_data && ack_q) begin
							nack_q <= 1'b1; // no ACK, go straight to stop.
							state  <= st_stop;
						end else begin
							state <= next_byte;
						end
					end
				end
			endcase
		end
	end

	// request copy and received bits.
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= req;
			rx_q  <= '0;
		end else if (sample_pt && state == st_rd_data && bit_cnt < 4'd8) begin
			rx_q <= {rx_q[6:0], sda_in};
		end
		if (sample_pt && bit_cnt == 4'd8) begin
			ack_q <= sda_in; // high means NACK.
		end
	end

	a_scl_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		!busy |-> !scl_pull)
		else $error("SCL pulled low outside a transfer.");

	a_done_busy: assert property (@(posedge clk) disable iff (!reset_n)
		done |-> $past(busy))
		else $error("done without a transfer in progress.");

endmodule

//--- src/i2c_pkg.sv
package i2c_pkg;

	// ========================================================================
	// bus timing
	// ========================================================================

	localparam int bit_div = 20; // system clocks per SCL bit.
	localparam int cnt_w   = $clog2(bit_div);

	// ticks inside one bit period.
	// scl_pull drops at a quarter and returns at three quarters,
	// so SCL is high over the middle half of every data bit.
	localparam logic [cnt_w-1:0] tick_scl_rise = cnt_w'(bit_div / 4);
	localparam logic [cnt_w-1:0] tick_sample   = cnt_w'(bit_div / 2); // SDA sampled here.
	localparam logic [cnt_w-1:0] tick_scl_fall = cnt_w'(bit_div * 3 / 4);
	localparam logic [cnt_w-1:0] tick_last     = cnt_w'(bit_div - 1);

	// ========================================================================
	// targets
	// ========================================================================

	localparam int n_targets = 4;
	localparam int n_regs    = 16; // per target.
	localparam int reg_aw    = $clog2(n_regs);

	// target k answers at dev_base + k.
	localparam logic [6:0] dev_base = 7'h50;

	// ========================================================================
	// types
	// ========================================================================

	typedef struct packed {
		logic [6:0] dev;
		logic       rw; // 1 = read.
	} i2c_addr_fields_t;

	// address byte, seen as shifted bits or as its fields.
	typedef union packed {
		logic [7:0]       raw;
		i2c_addr_fields_t fld;
	} i2c_addr_byte_u;

	typedef struct packed {
		logic       write; // 0 = read.
		logic [6:0] dev;
		logic [7:0] reg_addr;
		logic [7:0] wdata;
	} i2c_req_t;

	typedef struct packed {
		logic [7:0] rdata;
		logic       nack; // some byte was not acknowledged.
	} i2c_rsp_t;

endpackage
